//--- source/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [31:0] count_t;
	typedef logic [6:0] opcode_t;
	typedef logic [11:0] apbAddr_t;

	// RV32I major opcodes
	localparam opcode_t OPC_ALU_REG = 7'b0110011;
	localparam opcode_t OPC_ALU_IMM = 7'b0010011;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// funct3 codes of the supported ALU operations
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} aluOp_t;
	typedef enum logic {SRC_A_PC, SRC_A_REG} srcA_t;
	typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} srcB_t;
	typedef enum logic {WB_EX, WB_MEM} wbSrc_t;

	typedef enum logic [3:0] {
		IDLE,
		FETCH,
		DECODE,
		EXEC_R,
		EXEC_I,
		MEMORY,
		WRITEBACK,
		WRITEBACK_MEM,
		HALT
	} ctrlState_t;

	// APB byte address map
	localparam apbAddr_t IMEM_BASE = 12'h000;
	localparam apbAddr_t DMEM_BASE = 12'h100;
	localparam apbAddr_t CTRL_ADDR = 12'h200;
	localparam apbAddr_t COUNT_ADDR = 12'h204;

endpackage

//--- source/mainController.sv
module mainController (
	input logic clk,
	input logic rstN,
	input logic start,
	input cpuPkg::opcode_t opcode,
	output logic halted,
	output logic running,
	output logic pcWrite,
	output logic irWrite,
	output logic regWrite,
	output logic memWrite,
	output logic aluOverride,
	output logic retire,
	output cpuPkg::srcA_t srcA,
	output cpuPkg::srcB_t srcB,
	output cpuPkg::wbSrc_t wbSrc
);

	cpuPkg::ctrlState_t state;
	cpuPkg::ctrlState_t nextState;
	logic isMemOp;

	// Loads and stores always add base and offset
	assign isMemOp = (opcode == cpuPkg::OPC_LOAD) || (opcode == cpuPkg::OPC_STORE);

	assign halted = (state == cpuPkg::HALT);
	assign running = (state != cpuPkg::HALT) && (state != cpuPkg::IDLE);

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= cpuPkg::IDLE;
		else
			state <= nextState;
	end

	////////////////////////////////////////////////////////////////////////////
	// Per-state control outputs
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		pcWrite = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		retire = 1'b0;
		wbSrc = cpuPkg::WB_EX;
		// Operands held steady from EXEC through writeback
		aluOverride = isMemOp;
		srcA = cpuPkg::SRC_A_REG;
		srcB = (opcode == cpuPkg::OPC_ALU_REG) ? cpuPkg::SRC_B_REG : cpuPkg::SRC_B_IMM;

		case (state)
			cpuPkg::IDLE, cpuPkg::HALT: begin
				if (start)
					nextState = cpuPkg::FETCH;
			end
			cpuPkg::FETCH: begin
				irWrite = 1'b1;
				aluOverride = 1'b1;
				srcA = cpuPkg::SRC_A_PC;
				srcB = cpuPkg::SRC_B_FOUR;
				nextState = cpuPkg::DECODE;
			end
			cpuPkg::DECODE: begin
				// PC takes pc + 4
				pcWrite = 1'b1;
				aluOverride = 1'b1;
				srcA = cpuPkg::SRC_A_PC;
				srcB = cpuPkg::SRC_B_FOUR;
				case (opcode)
					cpuPkg::OPC_ALU_REG: nextState = cpuPkg::EXEC_R;
					cpuPkg::OPC_ALU_IMM: nextState = cpuPkg::EXEC_I;
					cpuPkg::OPC_LOAD: nextState = cpuPkg::EXEC_I;
					cpuPkg::OPC_STORE: nextState = cpuPkg::EXEC_I;
					// ECALL and anything unsupported stop the core
					default: nextState = cpuPkg::HALT;
				endcase
			end
			cpuPkg::EXEC_R: begin
				srcB = cpuPkg::SRC_B_REG;
				nextState = cpuPkg::MEMORY;
			end
			cpuPkg::EXEC_I: begin
				srcB = cpuPkg::SRC_B_IMM;
				nextState = cpuPkg::MEMORY;
			end
			cpuPkg::MEMORY: begin
				if (opcode == cpuPkg::OPC_STORE) begin
					memWrite = 1'b1;
					retire = 1'b1;
					nextState = cpuPkg::FETCH;
				end else if (opcode == cpuPkg::OPC_LOAD) begin
					nextState = cpuPkg::WRITEBACK_MEM;
				end else begin
					nextState = cpuPkg::WRITEBACK;
				end
			end
			cpuPkg::WRITEBACK: begin
				regWrite = 1'b1;
				retire = 1'b1;
				nextState = cpuPkg::FETCH;
			end
			cpuPkg::WRITEBACK_MEM: begin
				regWrite = 1'b1;
				retire = 1'b1;
				wbSrc = cpuPkg::WB_MEM;
				nextState = cpuPkg::FETCH;
			end
			default: nextState = cpuPkg::IDLE;
		endcase
	end

endmodule

//--- source/progCounter.sv
module progCounter (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic pcWrite,
	input logic retire,
	input cpuPkg::word_t nextPc,
	output cpuPkg::word_t pc,
	output cpuPkg::count_t count
);

	// Program always begins at address zero
	always_ff @(posedge clk) begin
		if (!rstN || start) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	// Retired instructions since the last start
	always_ff @(posedge clk) begin
		if (!rstN || start) begin
			count <= '0;
		end else if (retire) begin
			count <= count + 1'b1;
		end
	end

endmodule

//--- source/regFile.sv
module regFile (
	input logic clk,
	input logic rstN,
	input logic writeEn,
	input cpuPkg::regAddr_t readAddrA,
	input cpuPkg::regAddr_t readAddrB,
	input cpuPkg::regAddr_t writeAddr,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB
);

	cpuPkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 is hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- source/execUnit.sv
module execUnit (
	input logic clk,
	input logic rstN,
	input logic irWrite,
	input logic aluOverride,
	input cpuPkg::srcA_t srcA,
	input cpuPkg::srcB_t srcB,
	input cpuPkg::wbSrc_t wbSrc,
	input cpuPkg::word_t instrIn,
	input cpuPkg::word_t pc,
	input cpuPkg::word_t regA,
	input cpuPkg::word_t regB,
	input cpuPkg::word_t memRead,
	output cpuPkg::opcode_t opcode,
	output cpuPkg::regAddr_t rs1,
	output cpuPkg::regAddr_t rs2,
	output cpuPkg::regAddr_t rd,
	output cpuPkg::word_t aluResult,
	output cpuPkg::word_t aluOut,
	output cpuPkg::word_t storeData,
	output cpuPkg::word_t wbData
);

	cpuPkg::word_t instr;
	cpuPkg::word_t memData;
	cpuPkg::word_t imm;
	cpuPkg::word_t opA;
	cpuPkg::word_t opB;
	cpuPkg::aluOp_t aluOp;
	logic [2:0] funct3;

	always_ff @(posedge clk) begin
		if (!rstN)
			instr <= '0;
		else if (irWrite)
			instr <= instrIn;
	end

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// S-type splits the offset around rd
	assign imm = (opcode == cpuPkg::OPC_STORE) ?
		{{20{instr[31]}}, instr[31:25], instr[11:7]} : {{20{instr[31]}}, instr[31:20]};

	assign opA = (srcA == cpuPkg::SRC_A_PC) ? pc : regA;

	always_comb begin
		case (srcB)
			cpuPkg::SRC_B_IMM: opB = imm;
			cpuPkg::SRC_B_FOUR: opB = 32'd4;
			default: opB = regB;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		aluOp = cpuPkg::ALU_ADD;
		if (!aluOverride) begin
			case (funct3)
				// funct7 bit 5 selects SUB, register form only
				cpuPkg::F3_ADD_SUB:
					if (opcode == cpuPkg::OPC_ALU_REG && instr[30])
						aluOp = cpuPkg::ALU_SUB;
				cpuPkg::F3_SLT: aluOp = cpuPkg::ALU_SLT;
				cpuPkg::F3_XOR: aluOp = cpuPkg::ALU_XOR;
				cpuPkg::F3_OR: aluOp = cpuPkg::ALU_OR;
				cpuPkg::F3_AND: aluOp = cpuPkg::ALU_AND;
				default: aluOp = cpuPkg::ALU_ADD;
			endcase
		end
	end

	always_comb begin
		case (aluOp)
			cpuPkg::ALU_SUB: aluResult = opA - opB;
			cpuPkg::ALU_AND: aluResult = opA & opB;
			cpuPkg::ALU_OR: aluResult = opA | opB;
			cpuPkg::ALU_XOR: aluResult = opA ^ opB;
			cpuPkg::ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	// Result and load data registers, loaded every cycle
	always_ff @(posedge clk) begin
		aluOut <= aluResult;
		memData <= memRead;
	end

	assign storeData = regB;
	assign wbData = (wbSrc == cpuPkg::WB_MEM) ? memData : aluOut;

endmodule

//--- source/memBank.sv
module memBank #(
	parameter int MEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input cpuPkg::word_t coreAddr,
	input logic coreWriteEn,
	input cpuPkg::word_t coreWriteData,
	output cpuPkg::word_t coreReadData,
	input logic hostWriteEn,
	input logic [$clog2(MEM_WORDS)-1:0] hostIndex,
	input cpuPkg::word_t hostWriteData,
	output cpuPkg::word_t hostReadData
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	cpuPkg::word_t mem [MEM_WORDS];
	logic [IDX_W-1:0] coreIndex;

	// Byte address to word index, upper bits dropped
	assign coreIndex = coreAddr[IDX_W+1:2];

	// No writes land while reset is held; core wins over host
	always_ff @(posedge clk) begin
		if (rstN) begin
			if (coreWriteEn)
				mem[coreIndex] <= coreWriteData;
			else if (hostWriteEn)
				mem[hostIndex] <= hostWriteData;
		end
	end

	assign coreReadData = mem[coreIndex];
	assign hostReadData = mem[hostIndex];

endmodule

//--- source/apbBridge.sv
module apbBridge #(
	parameter int MEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input cpuPkg::apbAddr_t paddr,
	input cpuPkg::word_t pwdata,
	output cpuPkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	input logic halted,
	input logic running,
	input cpuPkg::count_t count,
	output logic imemWriteEn,
	output logic dmemWriteEn,
	output logic [$clog2(MEM_WORDS)-1:0] hostIndex,
	output cpuPkg::word_t hostWriteData,
	input cpuPkg::word_t imemReadData,
	input cpuPkg::word_t dmemReadData
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int SPAN = MEM_WORDS * 4;

	logic access;
	logic aligned;
	logic imemHit;
	logic dmemHit;
	logic ctrlHit;
	logic countHit;
	logic mapped;
	cpuPkg::apbAddr_t imemOff;
	cpuPkg::apbAddr_t dmemOff;

	assign access = psel && penable;
	assign aligned = (paddr[1:0] == 2'b00);

	// Addresses below a base wrap high and fail the span check
	assign imemOff = paddr - cpuPkg::IMEM_BASE;
	assign dmemOff = paddr - cpuPkg::DMEM_BASE;
	assign imemHit = aligned && (imemOff < SPAN);
	assign dmemHit = aligned && (dmemOff < SPAN);
	assign ctrlHit = (paddr == cpuPkg::CTRL_ADDR);
	assign countHit = (paddr == cpuPkg::COUNT_ADDR) && !pwrite;
	assign mapped = imemHit || dmemHit || ctrlHit || countHit;

	// Both bases sit on span boundaries, so one word index serves both memories
	assign hostIndex = paddr[IDX_W+1:2];
	assign hostWriteData = pwdata;

	// Memories are locked to the host during a run
	assign imemWriteEn = access && pwrite && imemHit && !running;
	assign dmemWriteEn = access && pwrite && dmemHit && !running;

	assign pready = 1'b1;
	assign pslverr = access && (!mapped || ((imemHit || dmemHit) && running));

	always_comb begin
		prdata = '0;
		if (imemHit && !running)
			prdata = imemReadData;
		else if (dmemHit && !running)
			prdata = dmemReadData;
		else if (ctrlHit)
			prdata = {30'b0, running, halted};
		else if (countHit)
			prdata = count;
	end

	// Start pulse follows the control write by one cycle
	always_ff @(posedge clk) begin
		if (!rstN)
			start <= 1'b0;
		else
			start <= access && pwrite && ctrlHit && pwdata[0] && !running;
	end

endmodule

//--- source/multiCycleCpu.sv
module multiCycleCpu #(
	parameter int MEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input cpuPkg::apbAddr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input cpuPkg::word_t pwdata,
	output cpuPkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	// Control
	logic start;
	logic halted;
	logic running;
	logic pcWrite;
	logic irWrite;
	logic regWrite;
	logic memWrite;
	logic aluOverride;
	logic retire;
	cpuPkg::srcA_t srcA;
	cpuPkg::srcB_t srcB;
	cpuPkg::wbSrc_t wbSrc;
	cpuPkg::opcode_t opcode;

	// Datapath
	cpuPkg::word_t pc;
	cpuPkg::count_t count;
	cpuPkg::word_t instrWord;
	cpuPkg::word_t regA;
	cpuPkg::word_t regB;
	cpuPkg::word_t memRead;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t aluOut;
	cpuPkg::word_t storeData;
	cpuPkg::word_t wbData;
	cpuPkg::regAddr_t rs1;
	cpuPkg::regAddr_t rs2;
	cpuPkg::regAddr_t rd;

	// Host side
	logic imemWriteEn;
	logic dmemWriteEn;
	logic [IDX_W-1:0] hostIndex;
	cpuPkg::word_t hostWriteData;
	cpuPkg::word_t imemReadData;
	cpuPkg::word_t dmemReadData;

	mainController u_ctrl (
		.clk(clk), .rstN(rstN), .start(start), .opcode(opcode),
		.halted(halted), .running(running), .pcWrite(pcWrite), .irWrite(irWrite),
		.regWrite(regWrite), .memWrite(memWrite), .aluOverride(aluOverride),
		.retire(retire), .srcA(srcA), .srcB(srcB), .wbSrc(wbSrc)
	);

	progCounter u_pc (
		.clk(clk), .rstN(rstN), .start(start), .pcWrite(pcWrite), .retire(retire),
		.nextPc(aluResult), .pc(pc), .count(count)
	);

	regFile u_regs (
		.clk(clk), .rstN(rstN), .writeEn(regWrite),
		.readAddrA(rs1), .readAddrB(rs2), .writeAddr(rd), .writeData(wbData),
		.readDataA(regA), .readDataB(regB)
	);

	execUnit u_exec (
		.clk(clk), .rstN(rstN), .irWrite(irWrite), .aluOverride(aluOverride),
		.srcA(srcA), .srcB(srcB), .wbSrc(wbSrc),
		.instrIn(instrWord), .pc(pc), .regA(regA), .regB(regB), .memRead(memRead),
		.opcode(opcode), .rs1(rs1), .rs2(rs2), .rd(rd),
		.aluResult(aluResult), .aluOut(aluOut), .storeData(storeData), .wbData(wbData)
	);

	// The core never writes instruction memory
	memBank #(.MEM_WORDS(MEM_WORDS)) instrMem (
		.clk(clk), .rstN(rstN),
		.coreAddr(pc), .coreWriteEn(1'b0), .coreWriteData('0), .coreReadData(instrWord),
		.hostWriteEn(imemWriteEn), .hostIndex(hostIndex),
		.hostWriteData(hostWriteData), .hostReadData(imemReadData)
	);

	memBank #(.MEM_WORDS(MEM_WORDS)) dataMem (
		.clk(clk), .rstN(rstN),
		.coreAddr(aluOut), .coreWriteEn(memWrite), .coreWriteData(storeData),
		.coreReadData(memRead),
		.hostWriteEn(dmemWriteEn), .hostIndex(hostIndex),
		.hostWriteData(hostWriteData), .hostReadData(dmemReadData)
	);

	apbBridge #(.MEM_WORDS(MEM_WORDS)) u_apb (
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .start(start), .halted(halted), .running(running),
		.count(count), .imemWriteEn(imemWriteEn), .dmemWriteEn(dmemWriteEn),
		.hostIndex(hostIndex), .hostWriteData(hostWriteData),
		.imemReadData(imemReadData), .dmemReadData(dmemReadData)
	);

endmodule

//--- tests/multiCycleCpu_chk.sv
module multiCycleCpu_chk (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlState_t state,
	input logic pcWrite,
	input logic irWrite,
	input logic regWrite,
	input logic memWrite
);
	timeunit 1ns;
	timeprecision 1ps;

	// Fetch and PC update are in separate states
	assert property (@(posedge clk) disable iff (!rstN) !(pcWrite && irWrite))
		else $error("pcWrite and irWrite high together");

	assert property (@(posedge clk) disable iff (!rstN)
		memWrite |-> (state == cpuPkg::MEMORY))
		else $error("memWrite outside MEMORY");

	assert property (@(posedge clk) disable iff (!rstN)
		regWrite |-> !(state inside {cpuPkg::HALT, cpuPkg::IDLE}))
		else $error("regWrite in HALT or IDLE");

	// Synchronous reset lands in IDLE
	assert property (@(posedge clk) !rstN |=> (state == cpuPkg::IDLE))
		else $error("state not IDLE after reset");

endmodule

bind mainController multiCycleCpu_chk u_chk (
	.clk(clk),
	.rstN(rstN),
	.state(state),
	.pcWrite(pcWrite),
	.irWrite(irWrite),
	.regWrite(regWrite),
	.memWrite(memWrite)
);

//--- tests/multiCycleCpu_tb.sv
module multiCycleCpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 64;
	localparam int APB_CYCLES = 3;
	// Five instructions and three data words per program
	localparam int LOAD_CYCLES = 8 * APB_CYCLES;
	localparam int RUN_CYCLES = 40;
	localparam logic [2:0] F3_WORD = 3'b010;

	typedef struct {
		logic isImm;
		logic sub;
		logic [2:0] f3;
		logic toX0;
		logic randOps;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t expResult;
	} row_t;

	logic clk;
	logic rstN;
	cpuPkg::apbAddr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	cpuPkg::word_t pwdata;
	cpuPkg::word_t prdata;
	logic pready;
	logic pslverr;

	row_t rows[$];
	int cycleLimit = 0;
	int cycles = 0;

	multiCycleCpu #(.MEM_WORDS(MEM_WORDS)) u_dut (
		.clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input cpuPkg::word_t got,
			input cpuPkg::word_t exp);
		if (got !== exp)
			failRun($sformatf("error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic checkCount(input string name, input cpuPkg::count_t got,
			input cpuPkg::count_t exp);
		if (got !== exp)
			failRun($sformatf("error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic checkErr(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("error: %s pslverr = %h, expected %h", name, got, exp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB host
	////////////////////////////////////////////////////////////////////////////
	task automatic apbWrite(input cpuPkg::apbAddr_t addr, input cpuPkg::word_t data,
			output logic err);
		@(posedge clk);
		#2;
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1;
		// Mid access cycle
		#10;
		if (pready !== 1'b1)
			failRun("pready was low during an APB write access cycle");
		err = pslverr;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input cpuPkg::apbAddr_t addr, output cpuPkg::word_t data,
			output logic err);
		@(posedge clk);
		#2;
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1;
		#10;
		if (pready !== 1'b1)
			failRun("pready was low during an APB read access cycle");
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding and RV32I reference results
	////////////////////////////////////////////////////////////////////////////
	function automatic cpuPkg::word_t encR(input logic sub, input logic [2:0] f3,
			input cpuPkg::regAddr_t rd, input cpuPkg::regAddr_t rs1,
			input cpuPkg::regAddr_t rs2);
		return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, cpuPkg::OPC_ALU_REG};
	endfunction

	function automatic cpuPkg::word_t encI(input logic [11:0] imm,
			input cpuPkg::regAddr_t rs1, input logic [2:0] f3,
			input cpuPkg::regAddr_t rd, input cpuPkg::opcode_t opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic cpuPkg::word_t encS(input logic [11:0] imm,
			input cpuPkg::regAddr_t rs2, input cpuPkg::regAddr_t rs1);
		return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], cpuPkg::OPC_STORE};
	endfunction

	function automatic cpuPkg::word_t rv32iResult(input logic isImm, input logic sub,
			input logic [2:0] f3, input cpuPkg::word_t a, input cpuPkg::word_t b);
		cpuPkg::word_t opB;
		// I-type immediates are 12 bits, sign extended
		opB = isImm ? {{20{b[11]}}, b[11:0]} : b;
		case (f3)
			3'b000: return (sub && !isImm) ? a - opB : a + opB;
			3'b010: return ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
			3'b100: return a ^ opB;
			3'b110: return a | opB;
			3'b111: return a & opB;
			default: return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Test table
	////////////////////////////////////////////////////////////////////////////
	task automatic addRow(input logic isImm, input logic sub, input logic [2:0] f3,
			input logic toX0, input logic randOps, input cpuPkg::word_t a,
			input cpuPkg::word_t b, input cpuPkg::word_t expResult);
		row_t r;
		r.isImm = isImm;
		r.sub = sub;
		r.f3 = f3;
		r.toX0 = toX0;
		r.randOps = randOps;
		r.a = a;
		r.b = b;
		r.expResult = expResult;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		// Register forms
		addRow(0, 0, cpuPkg::F3_ADD_SUB, 0, 0, 32'd5, 32'd7, 32'd12);
		addRow(0, 1, cpuPkg::F3_ADD_SUB, 0, 0, 32'd3, 32'd5, 32'hFFFF_FFFE);
		addRow(0, 0, cpuPkg::F3_AND, 0, 0, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
		addRow(0, 0, cpuPkg::F3_OR, 0, 0, 32'h0F0F_0000, 32'h0000_00F0, 32'h0F0F_00F0);
		addRow(0, 0, cpuPkg::F3_XOR, 0, 0, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555);
		addRow(0, 0, cpuPkg::F3_SLT, 0, 0, 32'hFFFF_FFFF, 32'd1, 32'd1);
		addRow(0, 0, cpuPkg::F3_SLT, 0, 0, 32'd5, 32'h8000_0000, 32'd0);
		// Immediate forms, negative immediates included
		addRow(1, 0, cpuPkg::F3_ADD_SUB, 0, 0, 32'd100, 32'hFFF, 32'd99);
		addRow(1, 0, cpuPkg::F3_AND, 0, 0, 32'h1234_5678, 32'h800, 32'h1234_5000);
		addRow(1, 0, cpuPkg::F3_OR, 0, 0, 32'h0000_0010, 32'h7FF, 32'h0000_07FF);
		addRow(1, 0, cpuPkg::F3_XOR, 0, 0, 32'h0000_FFFF, 32'hF00, 32'hFFFF_00FF);
		addRow(1, 0, cpuPkg::F3_SLT, 0, 0, 32'hFFFF_FFF0, 32'hFF8, 32'd1);
		// Result written to x0 must read back as zero
		addRow(0, 0, cpuPkg::F3_ADD_SUB, 1, 0, 32'd1, 32'd2, 32'd0);
		// Random operands
		addRow(0, 0, cpuPkg::F3_ADD_SUB, 0, 1, '0, '0, '0);
		addRow(0, 1, cpuPkg::F3_ADD_SUB, 0, 1, '0, '0, '0);
		addRow(0, 0, cpuPkg::F3_SLT, 0, 1, '0, '0, '0);
		addRow(1, 0, cpuPkg::F3_ADD_SUB, 0, 1, '0, '0, '0);
		addRow(1, 0, cpuPkg::F3_XOR, 0, 1, '0, '0, '0);
		addRow(1, 0, cpuPkg::F3_SLT, 0, 1, '0, '0, '0);
	endtask

	task automatic runRow(input row_t r);
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t expResult;
		cpuPkg::word_t prog[5];
		cpuPkg::word_t data;
		cpuPkg::word_t status;
		cpuPkg::regAddr_t rd;
		logic err;
		a = r.a;
		b = r.b;
		expResult = r.expResult;
		if (r.randOps) begin
			a = $urandom;
			b = $urandom;
			if (r.isImm)
				b = b & 32'h0000_0FFF;
			expResult = rv32iResult(r.isImm, r.sub, r.f3, a, b);
		end
		rd = r.toX0 ? 5'd0 : 5'd3;

		prog[0] = encI(12'd0, 5'd0, F3_WORD, 5'd1, cpuPkg::OPC_LOAD);
		prog[1] = encI(12'd4, 5'd0, F3_WORD, 5'd2, cpuPkg::OPC_LOAD);
		if (r.isImm)
			prog[2] = encI(b[11:0], 5'd1, r.f3, rd, cpuPkg::OPC_ALU_IMM);
		else
			prog[2] = encR(r.sub, r.f3, rd, 5'd1, 5'd2);
		prog[3] = encS(12'd8, rd, 5'd0);
		prog[4] = {25'b0, cpuPkg::OPC_SYSTEM};

		for (int i = 0; i < 5; i++) begin
			apbWrite(cpuPkg::IMEM_BASE + 12'(4 * i), prog[i], err);
			checkErr("imem write", err, 1'b0);
		end
		apbWrite(cpuPkg::DMEM_BASE, a, err);
		checkErr("dmem[0] write", err, 1'b0);
		apbWrite(cpuPkg::DMEM_BASE + 12'd4, b, err);
		checkErr("dmem[1] write", err, 1'b0);
		// Marker so a missing store shows up
		apbWrite(cpuPkg::DMEM_BASE + 12'd8, ~expResult, err);
		checkErr("dmem[2] write", err, 1'b0);

		apbWrite(cpuPkg::CTRL_ADDR, 32'd1, err);
		checkErr("ctrl start write", err, 1'b0);
		// Core is running now, so this write is refused
		apbWrite(cpuPkg::DMEM_BASE, ~a, err);
		checkErr("dmem[0] write while running", err, 1'b1);

		status = '0;
		while (status[0] !== 1'b1) begin
			apbRead(cpuPkg::CTRL_ADDR, status, err);
			checkErr("ctrl poll", err, 1'b0);
		end
		checkWord("ctrl status", status, 32'h0000_0001);

		apbRead(cpuPkg::DMEM_BASE + 12'd8, data, err);
		checkErr("dmem[2] read", err, 1'b0);
		checkWord("dmem[2]", data, expResult);
		apbRead(cpuPkg::DMEM_BASE, data, err);
		checkErr("dmem[0] read", err, 1'b0);
		checkWord("dmem[0]", data, a);
		apbRead(cpuPkg::COUNT_ADDR, data, err);
		checkErr("count read", err, 1'b0);
		checkCount("retired count", data, 32'd4);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		cpuPkg::word_t status;
		logic err;
		void'($urandom(41176));
		rstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		buildTable();
		cycleLimit = rows.size() * (LOAD_CYCLES + RUN_CYCLES) * 2;

		repeat (16) @(posedge clk);
		#2;
		rstN = 1'b1;

		// Idle after reset
		apbRead(cpuPkg::CTRL_ADDR, status, err);
		checkErr("ctrl read", err, 1'b0);
		checkWord("ctrl status", status, 32'h0);
		apbRead(cpuPkg::COUNT_ADDR, status, err);
		checkErr("count read", err, 1'b0);
		checkCount("retired count", status, 32'h0);

		// Unmapped accesses
		apbRead(12'h300, status, err);
		checkErr("read 0x300", err, 1'b1);
		apbWrite(cpuPkg::COUNT_ADDR, 32'h1, err);
		checkErr("write to count", err, 1'b1);

		foreach (rows[i])
			runRow(rows[i]);

		$display("Done: no errors");
		$finish;
	end

	// Watchdog
	initial begin
		wait (cycleLimit > 0);
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		failRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
	end

endmodule

//--- all.f
source/cpuPkg.sv
source/mainController.sv
source/progCounter.sv
source/regFile.sv
source/execUnit.sv
source/memBank.sv
source/apbBridge.sv
source/multiCycleCpu.sv
tests/multiCycleCpu_chk.sv
tests/multiCycleCpu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module multiCycleCpu_tb -f all.f -o simv
	./obj_dir/simv 2>&1 | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
